/* hdl/team_01_consts.svh */
// ************************************************************************
// Timing, address and LCD command constants for the keypad to LCD chip.
// Include this header wherever one of the macros is needed.
// ************************************************************************

`ifndef TEAM_01_CONSTS_SVH
`define TEAM_01_CONSTS_SVH

// Keypad scan, clock cycles per column
`define SCAN_DIV 16

// LCD write timing in clock cycles
`define LCD_E_CYCLES 8
`define LCD_HOLD_CYCLES 32

// Key storage in external memory
`define KEY_BASE 32'h3000_0000
`define KEY_SLOTS 16

// LCD init: 8-bit 2-line, display on, clear, entry increment
`define LCD_INIT_0 8'h38
`define LCD_INIT_1 8'h0C
`define LCD_INIT_2 8'h01
`define LCD_INIT_3 8'h06

`endif

/* hdl/team_01_pkg.sv */
// ************************************************************************
// Shared vector types and FSM state encodings for the keypad to LCD chip.
// Modules use scoped names in port lists and import it in their bodies.
// ************************************************************************

package team_01_pkg;

   // Wishbone bus fields
   typedef logic [31:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;
   typedef logic [3:0]  wb_sel_t;

   // Row times 4 plus column
   typedef logic [3:0]  key_code_t;

   // LCD data or command byte
   typedef logic [7:0]  lcd_byte_t;

   typedef enum logic {
      WB_IDLE,
      WB_BUSY
   } wb_state_e;

   typedef enum logic [1:0] {
      LCD_IDLE,
      LCD_SETUP,
      LCD_PULSE,
      LCD_HOLD
   } lcd_state_e;

   typedef enum logic [2:0] {
      CPU_INIT,
      CPU_IDLE,
      CPU_WRITE,
      CPU_READ,
      CPU_SHOW,
      CPU_WAIT_LCD
   } cpu_state_e;

endpackage

/* hdl/wishbone_manager.sv */
// ************************************************************************
// Wishbone classic manager for single reads and writes.
// A one-cycle read or write strobe starts a cycle; busy_o falls at the end.
// ************************************************************************

`timescale 1ns/1ps

module wishbone_manager (
   input  logic                  clk,
   input  logic                  arst_n_i,
   // Bus side
   input  team_01_pkg::wb_data_t dat_i,
   input  logic                  ack_i,
   // Request from the sequencer
   input  team_01_pkg::wb_data_t cpu_dat_i,
   input  team_01_pkg::wb_addr_t adr_i,
   input  team_01_pkg::wb_sel_t  sel_i,
   input  logic                  write_i,
   input  logic                  read_i,
   // Bus outputs
   output team_01_pkg::wb_addr_t adr_o,
   output team_01_pkg::wb_data_t dat_o,
   output team_01_pkg::wb_sel_t  sel_o,
   output logic                  we_o,
   output logic                  stb_o,
   output logic                  cyc_o,
   // Back to the sequencer
   output team_01_pkg::wb_data_t cpu_dat_o,
   output logic                  busy_o
);
   import team_01_pkg::*;

   wb_state_e state_q;
   logic      start;

   // New request only taken when idle
   assign start = (state_q == WB_IDLE) && (write_i || read_i);

   // Strobe, cycle and busy all follow the state
   assign stb_o  = (state_q == WB_BUSY);
   assign cyc_o  = (state_q == WB_BUSY);
   assign busy_o = (state_q == WB_BUSY);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WB_IDLE;
         we_o    <= 1'b0;
      end else begin
         case (state_q)
            WB_IDLE: begin
               if (start) begin
                  state_q <= WB_BUSY;
                  // Write wins if both strobes arrive together
                  we_o    <= write_i;
               end
            end
            WB_BUSY: begin
               // Slave may stall as long as it likes
               if (ack_i) begin
                  state_q <= WB_IDLE;
                  we_o    <= 1'b0;
               end
            end
            default: state_q <= WB_IDLE;
         endcase
      end
   end

   // Request fields held for the whole cycle
   always_ff @(posedge clk) begin
      if (start) begin
         adr_o <= adr_i;
         dat_o <= cpu_dat_i;
         sel_o <= sel_i;
      end
      // Read data captured on the acknowledge
      if (busy_o && ack_i && !we_o) begin
         cpu_dat_o <= dat_i;
      end
   end

endmodule

/* hdl/keypad_scanner.sv */
// ************************************************************************
// 4x4 matrix keypad scanner with debounce and one pulse per press.
// Columns are driven low one at a time; rows are read back active low.
// ************************************************************************

`timescale 1ns/1ps
`include "team_01_consts.svh"

module keypad_scanner (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic [3:0]             rows_i,
   output logic [3:0]             cols_o,
   output logic                   key_valid_o,
   output team_01_pkg::key_code_t key_code_o
);
   import team_01_pkg::*;

   localparam int div_w = $clog2(`SCAN_DIV);

   logic [div_w-1:0] div_q;
   logic [1:0]       col_q;
   logic [3:0]       rows_meta_q;
   logic [3:0]       rows_sync_q;
   logic [2:0]       hits_q;
   key_code_t        code_q;
   key_code_t        prev_code_q;
   logic             prev_single_q;
   logic             armed_q;
   logic [2:0]       row_hits;
   logic [2:0]       tot_hits;
   logic [1:0]       row_idx;
   logic             sample;
   logic             scan_end;
   key_code_t        scan_code;

   // Rows read at the last cycle of each column, well after settling
   assign sample   = (div_q == div_w'(`SCAN_DIV - 1));
   assign scan_end = sample && (col_q == 2'd3);

   // Count low rows in the current column
   always_comb begin
      row_hits = '0;
      row_idx  = '0;
      for (int r = 0; r < 4; r++) begin
         if (!rows_sync_q[r]) begin
            row_hits = row_hits + 3'd1;
            row_idx  = 2'(r);
         end
      end
      tot_hits = hits_q + row_hits;
   end

   // Key of this scan, valid when exactly one hit
   assign scan_code = (row_hits == 3'd1) ? {row_idx, col_q} : code_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         div_q         <= '0;
         col_q         <= '0;
         cols_o        <= '1;
         rows_meta_q   <= '1;
         rows_sync_q   <= '1;
         hits_q        <= '0;
         prev_single_q <= 1'b0;
         armed_q       <= 1'b1;
         key_valid_o   <= 1'b0;
      end else begin
         rows_meta_q <= rows_i;
         rows_sync_q <= rows_meta_q;
         cols_o      <= ~(4'b0001 << col_q);
         key_valid_o <= 1'b0;
         if (sample) begin
            div_q <= '0;
            col_q <= col_q + 2'd1;
            if (scan_end) begin
               hits_q        <= '0;
               prev_single_q <= (tot_hits == 3'd1);
               if (tot_hits == 3'd0) begin
                  // Empty scan re-arms the detector
                  armed_q <= 1'b1;
               end else if (tot_hits == 3'd1 && prev_single_q && armed_q &&
                            scan_code == prev_code_q) begin
                  key_valid_o <= 1'b1;
                  armed_q     <= 1'b0;
               end
            end else begin
               // Saturate, two or more means several keys
               hits_q <= (tot_hits > 3'd2) ? 3'd2 : tot_hits;
            end
         end else begin
            div_q <= div_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (sample && row_hits == 3'd1) begin
         code_q <= {row_idx, col_q};
      end
      if (scan_end) begin
         prev_code_q <= scan_code;
         key_code_o  <= scan_code;
      end
   end

endmodule

/* hdl/lcd_driver.sv */
// ************************************************************************
// HD44780 write timing for one byte in 8-bit write-only mode.
// A start pulse runs setup, enable pulse and hold; busy covers all three.
// ************************************************************************

`timescale 1ns/1ps
`include "team_01_consts.svh"

module lcd_driver (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   lcd_start_i,
   input  logic                   lcd_rs_i,
   input  team_01_pkg::lcd_byte_t lcd_data_i,
   output logic                   lcd_en_o,
   output logic                   lcd_rs_o,
   output team_01_pkg::lcd_byte_t lcd_data_o,
   output logic                   lcd_busy_o
);
   import team_01_pkg::*;

   // One counter shared by pulse and hold phases
   localparam int cnt_max = (`LCD_E_CYCLES > `LCD_HOLD_CYCLES) ?
                            `LCD_E_CYCLES : `LCD_HOLD_CYCLES;
   localparam int cnt_w   = $clog2(cnt_max);

   lcd_state_e       state_q;
   logic [cnt_w-1:0] cnt_q;

   assign lcd_en_o   = (state_q == LCD_PULSE);
   assign lcd_busy_o = (state_q != LCD_IDLE);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= LCD_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            LCD_IDLE: begin
               if (lcd_start_i) begin
                  state_q <= LCD_SETUP;
               end
            end
            LCD_SETUP: begin
               // One cycle of rs and data before enable rises
               state_q <= LCD_PULSE;
               cnt_q   <= cnt_w'(`LCD_E_CYCLES - 1);
            end
            LCD_PULSE: begin
               if (cnt_q == '0) begin
                  state_q <= LCD_HOLD;
                  cnt_q   <= cnt_w'(`LCD_HOLD_CYCLES - 1);
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            LCD_HOLD: begin
               // Gives the controller time to execute
               if (cnt_q == '0) begin
                  state_q <= LCD_IDLE;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: state_q <= LCD_IDLE;
         endcase
      end
   end

   // Byte and register select latched on start
   always_ff @(posedge clk) begin
      if (state_q == LCD_IDLE && lcd_start_i) begin
         lcd_rs_o   <= lcd_rs_i;
         lcd_data_o <= lcd_data_i;
      end
   end

endmodule

/* hdl/team_01_cpu.sv */
// ************************************************************************
// Sequencer: LCD init, then key to memory write, read back and display.
// Holds the keypad scanner and the LCD driver; talks to the bus manager.
// ************************************************************************

`timescale 1ns/1ps
`include "team_01_consts.svh"

module team_01_cpu (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   en_i,
   input  logic                   busy_i,
   input  team_01_pkg::wb_data_t  cpu_dat_i,
   input  logic [3:0]             rows_i,
   output team_01_pkg::wb_data_t  cpu_dat_o,
   output team_01_pkg::wb_addr_t  adr_o,
   output team_01_pkg::wb_sel_t   sel_o,
   output logic                   write_o,
   output logic                   read_o,
   output logic                   lcd_en_o,
   output logic                   lcd_rs_o,
   output team_01_pkg::lcd_byte_t lcd_data_o,
   output logic [3:0]             cols_o
);
   import team_01_pkg::*;

   localparam int slot_w = $clog2(`KEY_SLOTS);

   // Keypad layout, row by row
   localparam lcd_byte_t key_lut [16] = '{
      8'h31, 8'h32, 8'h33, 8'h41,
      8'h34, 8'h35, 8'h36, 8'h42,
      8'h37, 8'h38, 8'h39, 8'h43,
      8'h2A, 8'h30, 8'h23, 8'h44
   };

   cpu_state_e        state_q;
   logic              sent_q;
   logic [1:0]        init_idx_q;
   logic [slot_w-1:0] slot_q;
   lcd_byte_t         ascii_q;
   logic              key_valid;
   key_code_t         key_code;
   logic              lcd_start;
   logic              lcd_busy;
   logic              wb_go;
   lcd_byte_t         init_cmd;

   // Word slot per key, low byte only
   assign adr_o     = `KEY_BASE + wb_addr_t'({slot_q, 2'b00});
   assign sel_o     = 4'b0001;
   assign cpu_dat_o = wb_data_t'(ascii_q);

   // New bus strobe only when enabled and the manager is free
   assign wb_go   = en_i && !busy_i && !sent_q;
   assign write_o = (state_q == CPU_WRITE) && wb_go;
   assign read_o  = (state_q == CPU_READ) && wb_go;

   assign lcd_start = en_i && !lcd_busy &&
                      (state_q == CPU_INIT || state_q == CPU_SHOW);

   always_comb begin
      case (init_idx_q)
         2'd0:    init_cmd = `LCD_INIT_0;
         2'd1:    init_cmd = `LCD_INIT_1;
         2'd2:    init_cmd = `LCD_INIT_2;
         default: init_cmd = `LCD_INIT_3;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= CPU_INIT;
         sent_q     <= 1'b0;
         init_idx_q <= '0;
         slot_q     <= '0;
      end else begin
         case (state_q)
            CPU_INIT: begin
               if (lcd_start) begin
                  init_idx_q <= init_idx_q + 2'd1;
                  if (init_idx_q == 2'd3) begin
                     state_q <= CPU_WAIT_LCD;
                  end
               end
            end
            CPU_IDLE: begin
               // Keys only accepted here, others are dropped
               if (en_i && key_valid) begin
                  state_q <= CPU_WRITE;
               end
            end
            CPU_WRITE, CPU_READ: begin
               if (write_o || read_o) begin
                  sent_q <= 1'b1;
               end else if (sent_q && !busy_i) begin
                  sent_q  <= 1'b0;
                  state_q <= (state_q == CPU_WRITE) ? CPU_READ : CPU_SHOW;
               end
            end
            CPU_SHOW: begin
               if (lcd_start) begin
                  state_q <= CPU_WAIT_LCD;
                  slot_q  <= (slot_q == slot_w'(`KEY_SLOTS - 1)) ? '0 : slot_q + 1'b1;
               end
            end
            CPU_WAIT_LCD: begin
               if (!lcd_busy) begin
                  state_q <= CPU_IDLE;
               end
            end
            default: state_q <= CPU_IDLE;
         endcase
      end
   end

   // ASCII of the accepted key
   always_ff @(posedge clk) begin
      if (state_q == CPU_IDLE && en_i && key_valid) begin
         ascii_q <= key_lut[key_code];
      end
   end

   keypad_scanner u_keypad (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .rows_i      (rows_i),
      .cols_o      (cols_o),
      .key_valid_o (key_valid),
      .key_code_o  (key_code)
   );

   // Commands during init, read-back byte as data afterwards
   lcd_driver u_lcd (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .lcd_start_i (lcd_start),
      .lcd_rs_i    (state_q == CPU_SHOW),
      .lcd_data_i  ((state_q == CPU_INIT) ? init_cmd : cpu_dat_i[7:0]),
      .lcd_en_o    (lcd_en_o),
      .lcd_rs_o    (lcd_rs_o),
      .lcd_data_o  (lcd_data_o),
      .lcd_busy_o  (lcd_busy)
   );

endmodule

/* hdl/team_01.sv */
// ************************************************************************
// Chip top: GPIO pin map, output enables and tie-offs around the
// sequencer and the Wishbone manager. LCD on GPIO 1-11, keypad on 12-19.
// ************************************************************************

`timescale 1ns/1ps

module team_01 (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  en_i,
   // Logic analyzer, inputs unused
   input  logic [127:0]          la_data_in_i,
   input  logic [127:0]          la_oenb_i,
   output logic [127:0]          la_data_out_o,
   // GPIO, oeb is active low
   input  logic [33:0]           gpio_in_i,
   output logic [33:0]           gpio_out_o,
   output logic [33:0]           gpio_oeb_o,
   // Wishbone
   input  team_01_pkg::wb_data_t dat_i,
   input  logic                  ack_i,
   output team_01_pkg::wb_addr_t adr_o,
   output team_01_pkg::wb_data_t dat_o,
   output team_01_pkg::wb_sel_t  sel_o,
   output logic                  we_o,
   output logic                  stb_o,
   output logic                  cyc_o
);
   import team_01_pkg::*;

   wb_data_t  cpu_wdata;
   wb_data_t  cpu_rdata;
   wb_addr_t  cpu_adr;
   wb_sel_t   cpu_sel;
   logic      cpu_write;
   logic      cpu_read;
   logic      wb_busy;
   logic      lcd_en;
   logic      lcd_rs;
   lcd_byte_t lcd_data;
   logic [3:0] cols;

   assign la_data_out_o = '0;

   // 33:20 unused, 19:16 cols, 15:12 rows, 11:4 data, 3 rw low, 2 rs, 1 en
   assign gpio_out_o = {14'b0, cols, 4'b0, lcd_data, 1'b0, lcd_rs, lcd_en, 1'b0};
   assign gpio_oeb_o = {{14{1'b1}}, 4'b0000, 4'b1111, 11'b0, 1'b1};

   wishbone_manager u_wb (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .dat_i     (dat_i),
      .ack_i     (ack_i),
      .cpu_dat_i (cpu_wdata),
      .adr_i     (cpu_adr),
      .sel_i     (cpu_sel),
      .write_i   (cpu_write),
      .read_i    (cpu_read),
      .adr_o     (adr_o),
      .dat_o     (dat_o),
      .sel_o     (sel_o),
      .we_o      (we_o),
      .stb_o     (stb_o),
      .cyc_o     (cyc_o),
      .cpu_dat_o (cpu_rdata),
      .busy_o    (wb_busy)
   );

   team_01_cpu u_cpu (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .en_i       (en_i),
      .busy_i     (wb_busy),
      .cpu_dat_i  (cpu_rdata),
      .rows_i     (gpio_in_i[15:12]),
      .cpu_dat_o  (cpu_wdata),
      .adr_o      (cpu_adr),
      .sel_o      (cpu_sel),
      .write_o    (cpu_write),
      .read_o     (cpu_read),
      .lcd_en_o   (lcd_en),
      .lcd_rs_o   (lcd_rs),
      .lcd_data_o (lcd_data),
      .cols_o     (cols)
   );

endmodule

/* tb/team_01_assert.sv */
// ************************************************************************
// Concurrent protocol checks on the Wishbone bus, the LCD enable pulse
// and the keypad column drive. Bound into the chip top by the bind below.
// ************************************************************************

`timescale 1ns/1ps
`include "team_01_consts.svh"

module team_01_assert (
   input logic                  clk,
   input logic                  arst_n_i,
   input logic                  stb_i,
   input logic                  cyc_i,
   input logic                  ack_i,
   input logic                  we_i,
   input team_01_pkg::wb_addr_t adr_i,
   input team_01_pkg::wb_data_t wdat_i,
   input team_01_pkg::wb_sel_t  sel_i,
   input logic                  lcd_en_i,
   input logic [3:0]            cols_i
);

   // Violations seen so far for the testbench
   int unsigned fail_cnt = 0;
   int unsigned en_cnt_q;
   logic        scan_run_q;

   // Length of the current enable pulse
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         en_cnt_q   <= 0;
         scan_run_q <= 1'b0;
      end else begin
         en_cnt_q   <= lcd_en_i ? en_cnt_q + 1 : 0;
         // Columns leave the all-high reset value one clock after reset
         scan_run_q <= 1'b1;
      end
   end

   // Strobe and cycle drop together right after the acknowledge
   a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
      stb_i && ack_i |=> !stb_i && !cyc_i)
      else begin
         $error("stb_o and cyc_o did not fall together after ack");
         fail_cnt = fail_cnt + 1;
      end

   // Slave stall keeps strobe and cycle both high
   a_stb_wait: assert property (@(posedge clk) disable iff (!arst_n_i)
      stb_i && !ack_i |=> stb_i && cyc_i)
      else begin
         $error("stb_o or cyc_o fell before ack");
         fail_cnt = fail_cnt + 1;
      end

   // Request fields frozen while the slave stalls
   a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      stb_i && !ack_i |=> $stable(adr_i) && $stable(wdat_i) && $stable(sel_i) && $stable(we_i))
      else begin
         $error("Bus lines changed while the strobe waited for ack");
         fail_cnt = fail_cnt + 1;
      end

   a_en_width: assert property (@(posedge clk) disable iff (!arst_n_i)
      $fell(lcd_en_i) |-> en_cnt_q == `LCD_E_CYCLES)
      else begin
         $error("LCD enable pulse has the wrong width");
         fail_cnt = fail_cnt + 1;
      end

   a_one_col: assert property (@(posedge clk) disable iff (!arst_n_i)
      scan_run_q |-> $onehot(~cols_i))
      else begin
         $error("Keypad columns do not have exactly one low line");
         fail_cnt = fail_cnt + 1;
      end

endmodule

// Top ports carry both the manager and the LCD driver outputs
bind team_01 team_01_assert u_assert (
   .clk      (clk),
   .arst_n_i (arst_n_i),
   .stb_i    (stb_o),
   .cyc_i    (cyc_o),
   .ack_i    (ack_i),
   .we_i     (we_o),
   .adr_i    (adr_o),
   .wdat_i   (dat_o),
   .sel_i    (sel_o),
   .lcd_en_i (gpio_out_o[1]),
   .cols_i   (gpio_out_o[19:16])
);

/* tb/tb_team_01.sv */
// ************************************************************************
// Testbench for the keypad to LCD chip top. A Wishbone memory model, a
// keypad model and an LCD monitor surround the DUT; expected bytes come
// from a reference keymap. Build with the src.f file list.
// ************************************************************************

`timescale 1ns/1ps
`include "team_01_consts.svh"

module tb_team_01;
   import team_01_pkg::*;

   localparam int n_rand_keys    = 20;
   localparam int press_cycles   = 400;
   localparam int release_cycles = 400;
   localparam int long_hold      = 2000;
   // Random keys plus long hold as three units, disabled key and resumed key
   localparam int press_units    = n_rand_keys + 3 + 2;
   localparam int init_cycles    = 5 + 4 * (`LCD_E_CYCLES + `LCD_HOLD_CYCLES + 4);
   localparam int limit_cycles   = init_cycles + press_units * (press_cycles + release_cycles)
                                   + 8 * 4 * `SCAN_DIV;

   localparam lcd_byte_t init_seq [4] = '{`LCD_INIT_0, `LCD_INIT_1, `LCD_INIT_2, `LCD_INIT_3};

   logic         clk;
   logic         arst_n_i;
   logic         en_i;
   logic [127:0] la_data_in_i;
   logic [127:0] la_oenb_i;
   logic [127:0] la_data_out_o;
   logic [33:0]  gpio_in_i = 34'h0_0000_F000;
   logic [33:0]  gpio_out_o;
   logic [33:0]  gpio_oeb_o;
   wb_data_t     dat_i = '0;
   logic         ack_i = 1'b0;
   wb_addr_t     adr_o;
   wb_data_t     dat_o;
   wb_sel_t      sel_o;
   logic         we_o;
   logic         stb_o;
   logic         cyc_o;

   integer       seed;
   wb_data_t     mem [16];
   int           wait_left;
   bit           counting;
   logic [3:0]   mem_idx;
   logic         key_down = 1'b0;
   key_code_t    key_now = '0;
   logic [3:0]   rows_drv;
   logic [3:0]   cols;
   logic         lcd_en_q = 1'b0;

   // Completed bus cycles and LCD writes in arrival order
   logic         bus_we_q  [$];
   wb_addr_t     bus_adr_q [$];
   wb_data_t     bus_dat_q [$];
   wb_sel_t      bus_sel_q [$];
   logic [8:0]   lcd_q     [$];

   team_01 uut (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .en_i          (en_i),
      .la_data_in_i  (la_data_in_i),
      .la_oenb_i     (la_oenb_i),
      .la_data_out_o (la_data_out_o),
      .gpio_in_i     (gpio_in_i),
      .gpio_out_o    (gpio_out_o),
      .gpio_oeb_o    (gpio_oeb_o),
      .dat_i         (dat_i),
      .ack_i         (ack_i),
      .adr_o         (adr_o),
      .dat_o         (dat_o),
      .sel_o         (sel_o),
      .we_o          (we_o),
      .stb_o         (stb_o),
      .cyc_o         (cyc_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Keypad layout 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
   function automatic lcd_byte_t key_ascii(input key_code_t k);
      case (k)
         4'd0:  key_ascii = "1";
         4'd1:  key_ascii = "2";
         4'd2:  key_ascii = "3";
         4'd3:  key_ascii = "A";
         4'd4:  key_ascii = "4";
         4'd5:  key_ascii = "5";
         4'd6:  key_ascii = "6";
         4'd7:  key_ascii = "B";
         4'd8:  key_ascii = "7";
         4'd9:  key_ascii = "8";
         4'd10: key_ascii = "9";
         4'd11: key_ascii = "C";
         4'd12: key_ascii = "*";
         4'd13: key_ascii = "0";
         4'd14: key_ascii = "#";
         4'd15: key_ascii = "D";
      endcase
   endfunction

   // LCD on 1 to 11 and columns on 16 to 19 are outputs and all else input
   function automatic logic [33:0] oeb_map();
      logic [33:0] m;
      for (int b = 0; b < 34; b++) begin
         m[b] = !((b >= 1 && b <= 11) || (b >= 16 && b <= 19));
      end
      return m;
   endfunction

   task automatic stop_run();
      $display("Done: errors found");
      $fatal(1, "Simulation stopped on the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
         stop_run();
      end
   endtask

   // Memory slave with ack after 0 to 3 extra cycles
   always @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 16; i++) begin
            mem[i] = 32'hC0DE_0000 | (32'(i) * 32'h0000_1111);
         end
         ack_i     <= 1'b0;
         dat_i     <= '0;
         counting  = 1'b0;
         wait_left = 0;
      end else if (ack_i) begin
         ack_i <= 1'b0;
      end else if (stb_o && cyc_o) begin
         if (!counting) begin
            wait_left = int'($unsigned($random(seed)) % 4);
            counting  = 1'b1;
         end
         if (wait_left == 0) begin
            counting = 1'b0;
            ack_i   <= 1'b1;
            mem_idx  = adr_o[5:2];
            if (we_o) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel_o[b]) begin
                     mem[mem_idx][8*b +: 8] = dat_o[8*b +: 8];
                  end
               end
            end else begin
               dat_i <= mem[mem_idx];
            end
            bus_we_q.push_back(we_o);
            bus_adr_q.push_back(adr_o);
            bus_dat_q.push_back(dat_o);
            bus_sel_q.push_back(sel_o);
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

   assign cols = gpio_out_o[19:16];

   // Pressed key pulls its row low while its column is driven low
   always @(posedge clk) begin
      rows_drv = 4'hF;
      if (key_down && !cols[key_now[1:0]]) begin
         rows_drv[key_now[3:2]] = 1'b0;
      end
      gpio_in_i <= {18'b0, rows_drv, 12'b0};
   end

   // LCD write taken when the enable has just fallen while rs and data still hold
   always @(posedge clk) begin
      lcd_en_q <= gpio_out_o[1];
      if (lcd_en_q && !gpio_out_o[1]) begin
         lcd_q.push_back({gpio_out_o[2], gpio_out_o[11:4]});
      end
   end

   always @(posedge clk) begin
      if (uut.u_assert.fail_cnt != 0) begin
         $display("A bound protocol assertion failed");
         stop_run();
      end
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the test did not finish within %0d cycles", limit_cycles);
      stop_run();
   end

   task automatic wait_lcd(input int n);
      while (lcd_q.size() < n) begin
         @(posedge clk);
      end
   endtask

   task automatic wait_bus(input int n);
      while (bus_we_q.size() < n) begin
         @(posedge clk);
      end
   endtask

   task automatic press_key(input key_code_t k, input int hold);
      @(posedge clk);
      key_now  <= k;
      key_down <= 1'b1;
      repeat (hold) @(posedge clk);
      key_down <= 1'b0;
      repeat (release_cycles) @(posedge clk);
   endtask

   // Write then read of one slot and then one data write to the LCD
   task automatic expect_transfer(input key_code_t k, input int slot);
      lcd_byte_t  ch;
      wb_addr_t   adr;
      logic [8:0] ent;
      ch  = key_ascii(k);
      adr = `KEY_BASE + wb_addr_t'(4 * slot);
      wait_bus(2);
      wait_lcd(1);
      check_value("we_o (write)", 64'(bus_we_q[0]), 64'(1));
      check_value("adr_o (write)", 64'(bus_adr_q[0]), 64'(adr));
      check_value("sel_o (write)", 64'(bus_sel_q[0]), 64'(4'b0001));
      check_value("dat_o (write)", 64'(bus_dat_q[0]), 64'(ch));
      check_value("we_o (read)", 64'(bus_we_q[1]), 64'(0));
      check_value("adr_o (read)", 64'(bus_adr_q[1]), 64'(adr));
      check_value("bus cycles per key", 64'(bus_we_q.size()), 64'(2));
      ent = lcd_q.pop_front();
      check_value("lcd rs", 64'(ent[8]), 64'(1));
      check_value("lcd data", 64'(ent[7:0]), 64'(ch));
      check_value("lcd writes per key", 64'(lcd_q.size()), 64'(0));
      bus_we_q.delete();
      bus_adr_q.delete();
      bus_dat_q.delete();
      bus_sel_q.delete();
   endtask

   initial begin
      key_code_t  keys [n_rand_keys];
      int         n_acc;
      logic [8:0] ent;
      seed         = 32'h5df2;
      n_acc        = 0;
      arst_n_i     = 1'b0;
      en_i         = 1'b1;
      la_data_in_i = '0;
      la_oenb_i    = '1;
      for (int i = 0; i < n_rand_keys; i++) begin
         keys[i] = key_code_t'($random(seed));
      end
      repeat (5) @(posedge clk);
      arst_n_i <= 1'b1;

      // Init commands with rs low and the fixed pin directions
      wait_lcd(4);
      for (int i = 0; i < 4; i++) begin
         ent = lcd_q.pop_front();
         check_value("lcd rs (init)", 64'(ent[8]), 64'(0));
         check_value("lcd data (init)", 64'(ent[7:0]), 64'(init_seq[i]));
      end
      check_value("gpio_oeb_o", 64'(gpio_oeb_o), 64'(oeb_map()));
      check_value("gpio_out_o[3] lcd rw", 64'(gpio_out_o[3]), 64'(0));
      // Input pins drive zero
      check_value("gpio_out_o input pins", 64'(gpio_out_o & oeb_map()), 64'(0));
      check_value("la_data_out_o any bit", 64'(|la_data_out_o), 64'(0));
      check_value("bus cycles during init", 64'(bus_we_q.size()), 64'(0));

      // Twenty keys wrap the slot address
      for (int i = 0; i < n_rand_keys; i++) begin
         press_key(keys[i], press_cycles);
         expect_transfer(keys[i], n_acc % `KEY_SLOTS);
         n_acc++;
      end

      // Long hold over many scans
      press_key(4'd5, long_hold);
      expect_transfer(4'd5, n_acc % `KEY_SLOTS);
      n_acc++;

      // Key ignored while disabled and the slot stays
      @(posedge clk);
      en_i <= 1'b0;
      press_key(4'd12, press_cycles);
      check_value("bus cycles while disabled", 64'(bus_we_q.size()), 64'(0));
      check_value("lcd writes while disabled", 64'(lcd_q.size()), 64'(0));
      @(posedge clk);
      en_i <= 1'b1;
      press_key(4'd15, press_cycles);
      expect_transfer(4'd15, n_acc % `KEY_SLOTS);

      if (uut.u_assert.fail_cnt == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Bound protocol assertions failed %0d times", uut.u_assert.fail_cnt);
         stop_run();
      end
   end

endmodule

/* src.f */
+incdir+hdl
hdl/team_01_pkg.sv
hdl/wishbone_manager.sv
hdl/keypad_scanner.sv
hdl/lcd_driver.sv
hdl/team_01_cpu.sv
hdl/team_01.sv
tb/team_01_assert.sv
tb/tb_team_01.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

rm -f sim.log

verilator --binary --assert --top-module tb_team_01 -f src.f -o tb_team_01 \
   && ./obj_dir/tb_team_01 > sim.log 2>&1 \
   || echo "Build or simulation returned an error"

cat sim.log 2>/dev/null

grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
